// ==== design/apf_cfg_defs.svh ====
// ========================================
// config register map and ROM load windows
// offsets are byte offsets from the config base
// ========================================
`ifndef APF_CFG_DEFS_SVH
`define APF_CFG_DEFS_SVH

`define APF_CFG_BASE            32'hF000_0000

// word offsets inside the config window
`define APF_REG_CTRL_MAP1       8'h00
`define APF_REG_CTRL_MAP2       8'h04
`define APF_REG_DIPSW           8'h08
`define APF_REG_SYSTEM_TYPE     8'h0C
`define APF_REG_MEMCARD_EN      8'h10
`define APF_REG_USE_MOUSE       8'h14
`define APF_REG_VIDEO_MODE      8'h18
`define APF_REG_CH_ENABLE       8'h1C
`define APF_REG_SND_ENABLE      8'h20
`define APF_REG_PCHIP_MAIN      8'h24
`define APF_REG_USE_PCM         8'h28
`define APF_REG_PCHIP_SUB       8'h2C
`define APF_REG_CMC_CHIP        8'h30
`define APF_REG_SCREEN_X        8'h34
`define APF_REG_SCREEN_Y        8'h38
`define APF_REG_V2_OFFSET       8'h3C
`define APF_REG_CART_CHIP       8'h40

// ROM windows, matched on the top address bits
`define APF_P2_PREFIX_W         9
`define APF_P2_PREFIX           9'h020
`define APF_M_PREFIX_W          13
`define APF_M_PREFIX            13'h021F
`define APF_V1_PREFIX_W         8
`define APF_V1_PREFIX           8'h20

`define APF_RST_DIPSW           8'hFF
`define APF_RST_SYSTEM_TYPE     2'd1
`define APF_RST_CH_ENABLE       6'h3F
`define APF_RST_SND_ENABLE      4'hF

`endif

// ==== design/apf_cfg_pkg.sv ====
// ========================================
// shared types for the core config block
// ========================================
package apf_cfg_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [3:0]  controller_map_1;
		logic [3:0]  controller_map_2;
		logic [7:0]  dipsw;
		logic [1:0]  system_type;
		logic [1:0]  memory_card_enable;
		logic [1:0]  use_mouse;
		logic        video_mode;
		logic [5:0]  ch_enable;
		logic [3:0]  snd_enable;
		logic        use_pcm;
		logic [1:0]  cmc_chip;
		logic [1:0]  cart_chip;
		logic [2:0]  cart_pchip;
		logic [31:0] screen_x_pos;
		logic [31:0] screen_y_pos;
		logic [23:0] v2_offset;
	} core_cfg_t;

	// one strobe per window, address shared
	typedef struct packed {
		logic        p2_wr;
		logic        m_wr;
		logic        v1_wr;
		logic [23:0] addr;
	} rom_wr_t;

	typedef logic [22:0] p2_mask_t;
	typedef logic [18:0] m_mask_t;
	typedef logic [23:0] v1_mask_t;

	// pocket key bitmap, bit 15 first
	typedef struct packed {
		logic face_start;
		logic face_select;
		logic trig_r3;
		logic trig_l3;
		logic trig_r2;
		logic trig_l2;
		logic trig_r1;
		logic trig_l1;
		logic face_y;
		logic face_x;
		logic face_b;
		logic face_a;
		logic dpad_right;
		logic dpad_left;
		logic dpad_down;
		logic dpad_up;
	} pad_keys_t;

	// core joystick layout, bit 9 first
	typedef struct packed {
		logic select;
		logic start;
		logic btn_d;
		logic btn_c;
		logic btn_b;
		logic btn_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage

// ==== design/apb_cfg_regs.sv ====
// ========================================
// zero-wait APB slave, no pready or pslverr
// ROM window writes carry address only
// ========================================
`timescale 1ns/1ns
`include "apf_cfg_defs.svh"

module apb_cfg_regs (
	input  logic                   clk_74a,
	input  logic                   reset_l_main,
	input  apf_cfg_pkg::apb_req_t  apb,
	output logic [31:0]            prdata,
	output apf_cfg_pkg::core_cfg_t cfg,
	output apf_cfg_pkg::rom_wr_t   rom_wr
);

	localparam logic [31:0] cfg_base = `APF_CFG_BASE;

	logic                   access;
	logic                   wr_en;
	logic                   rd_en;
	logic                   cfg_hit;
	logic [7:0]             offset;
	logic [31:0]            rd_data;
	logic                   pchip_main;
	logic [2:0]             pchip_sub;
	logic [2:0]             pchip_dec;
	apf_cfg_pkg::core_cfg_t cfg_q;

	assign access  = apb.psel & apb.penable;
	assign wr_en   = access & apb.pwrite;
	assign rd_en   = access & ~apb.pwrite;
	assign cfg_hit = (apb.paddr[31:8] == cfg_base[31:8]);
	assign offset  = apb.paddr[7:0];

	// window strobes live for the access cycle only
	assign rom_wr.p2_wr = wr_en &
		(apb.paddr[31 -: `APF_P2_PREFIX_W] == `APF_P2_PREFIX);
	assign rom_wr.m_wr  = wr_en &
		(apb.paddr[31 -: `APF_M_PREFIX_W] == `APF_M_PREFIX);
	assign rom_wr.v1_wr = wr_en &
		(apb.paddr[31 -: `APF_V1_PREFIX_W] == `APF_V1_PREFIX);
	assign rom_wr.addr  = apb.paddr[23:0];

	// protection chip number from main flag and sub select
	always_comb begin
		pchip_dec = 3'd0;
		if (pchip_main)
			pchip_dec = 3'd2;
		else if (pchip_sub >= 3'd1 && pchip_sub <= 3'd5)
			pchip_dec = pchip_sub + 3'd2;
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cfg_q.controller_map_1   <= '0;
			cfg_q.controller_map_2   <= '0;
			cfg_q.dipsw              <= `APF_RST_DIPSW;
			cfg_q.system_type        <= `APF_RST_SYSTEM_TYPE;
			cfg_q.memory_card_enable <= '0;
			cfg_q.use_mouse          <= '0;
			cfg_q.video_mode         <= 1'b0;
			cfg_q.ch_enable          <= `APF_RST_CH_ENABLE;
			cfg_q.snd_enable         <= `APF_RST_SND_ENABLE;
			cfg_q.use_pcm            <= 1'b0;
			cfg_q.cmc_chip           <= '0;
			cfg_q.cart_chip          <= '0;
			cfg_q.cart_pchip         <= '0;
			cfg_q.screen_x_pos       <= '0;
			cfg_q.screen_y_pos       <= '0;
			cfg_q.v2_offset          <= '0;
			pchip_main               <= 1'b0;
			pchip_sub                <= '0;
		end else begin
			if (wr_en && cfg_hit) begin
				case (offset)
					`APF_REG_CTRL_MAP1:   cfg_q.controller_map_1   <= apb.pwdata[3:0];
					`APF_REG_CTRL_MAP2:   cfg_q.controller_map_2   <= apb.pwdata[3:0];
					`APF_REG_DIPSW:       cfg_q.dipsw              <= apb.pwdata[7:0];
					`APF_REG_SYSTEM_TYPE: cfg_q.system_type        <= apb.pwdata[1:0];
					`APF_REG_MEMCARD_EN:  cfg_q.memory_card_enable <= apb.pwdata[1:0];
					`APF_REG_USE_MOUSE:   cfg_q.use_mouse          <= apb.pwdata[1:0];
					`APF_REG_VIDEO_MODE:  cfg_q.video_mode         <= apb.pwdata[0];
					`APF_REG_CH_ENABLE:   cfg_q.ch_enable          <= apb.pwdata[5:0];
					`APF_REG_SND_ENABLE:  cfg_q.snd_enable         <= apb.pwdata[3:0];
					`APF_REG_PCHIP_MAIN:  pchip_main               <= apb.pwdata[0];
					`APF_REG_USE_PCM:     cfg_q.use_pcm            <= apb.pwdata[0];
					`APF_REG_PCHIP_SUB:   pchip_sub                <= apb.pwdata[2:0];
					`APF_REG_CMC_CHIP:    cfg_q.cmc_chip           <= apb.pwdata[1:0];
					`APF_REG_SCREEN_X:    cfg_q.screen_x_pos       <= apb.pwdata;
					`APF_REG_SCREEN_Y:    cfg_q.screen_y_pos       <= apb.pwdata;
					`APF_REG_V2_OFFSET:   cfg_q.v2_offset          <= apb.pwdata[23:0];
					`APF_REG_CART_CHIP:   cfg_q.cart_chip          <= apb.pwdata[1:0];
					default: ;
				endcase
			end
			// one cycle behind main and sub
			cfg_q.cart_pchip <= pchip_dec;
		end
	end

	// read back, zero outside the config window
	always_comb begin
		rd_data = '0;
		if (cfg_hit) begin
			case (offset)
				`APF_REG_CTRL_MAP1:   rd_data = 32'(cfg_q.controller_map_1);
				`APF_REG_CTRL_MAP2:   rd_data = 32'(cfg_q.controller_map_2);
				`APF_REG_DIPSW:       rd_data = 32'(cfg_q.dipsw);
				`APF_REG_SYSTEM_TYPE: rd_data = 32'(cfg_q.system_type);
				`APF_REG_MEMCARD_EN:  rd_data = 32'(cfg_q.memory_card_enable);
				`APF_REG_USE_MOUSE:   rd_data = 32'(cfg_q.use_mouse);
				`APF_REG_VIDEO_MODE:  rd_data = 32'(cfg_q.video_mode);
				`APF_REG_CH_ENABLE:   rd_data = 32'(cfg_q.ch_enable);
				`APF_REG_SND_ENABLE:  rd_data = 32'(cfg_q.snd_enable);
				`APF_REG_PCHIP_MAIN:  rd_data = 32'(pchip_main);
				`APF_REG_USE_PCM:     rd_data = 32'(cfg_q.use_pcm);
				`APF_REG_PCHIP_SUB:   rd_data = 32'(pchip_sub);
				`APF_REG_CMC_CHIP:    rd_data = 32'(cfg_q.cmc_chip);
				`APF_REG_SCREEN_X:    rd_data = cfg_q.screen_x_pos;
				`APF_REG_SCREEN_Y:    rd_data = cfg_q.screen_y_pos;
				`APF_REG_V2_OFFSET:   rd_data = 32'(cfg_q.v2_offset);
				`APF_REG_CART_CHIP:   rd_data = 32'(cfg_q.cart_chip);
				default:              rd_data = '0;
			endcase
		end
	end

	assign prdata = rd_en ? rd_data : '0;
	assign cfg    = cfg_q;

endmodule

// ==== design/rom_mask_tracker.sv ====
// ========================================
// mask_t must be a plain vector of 24 bits or less
// mask only grows until reset
// ========================================
`timescale 1ns/1ns

module rom_mask_tracker #(
	parameter type mask_t = logic [23:0]
) (
	input  logic        clk_74a,
	input  logic        reset_l_main,
	input  logic        wr,
	input  logic [23:0] addr,
	output mask_t       mask
);

	localparam int mask_w = $bits(mask_t);

	logic [mask_w-1:0] therm;
	logic [mask_w-1:0] held;

	// bit i set when any address bit at or above i is set
	always_comb begin : therm_build
		logic seen;
		seen = 1'b0;
		for (int i = mask_w - 1; i >= 0; i--) begin
			seen     = seen | addr[i];
			therm[i] = seen;
		end
	end

	// keeps the largest thermometer seen so far
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main)
			held <= '0;
		else if (wr)
			held <= held | therm;
	end

	assign mask = mask_t'(held);

endmodule

// ==== design/pad_input_stage.sv ====
// ========================================
// maps 1 and 2 reorder the face buttons, others use default
// ========================================
`timescale 1ns/1ns

module pad_input_stage (
	input  logic                   clk_74a,
	input  logic                   reset_l_main,
	input  apf_cfg_pkg::pad_keys_t cont1_key,
	input  apf_cfg_pkg::pad_keys_t cont2_key,
	input  logic [3:0]             controller_map_1,
	input  logic [3:0]             controller_map_2,
	input  logic                   dataslot_allcomplete,
	input  logic                   core_run,
	output apf_cfg_pkg::joy_t      joystick_0,
	output apf_cfg_pkg::joy_t      joystick_1,
	output logic                   start_system
);

	function automatic apf_cfg_pkg::joy_t remap(input apf_cfg_pkg::pad_keys_t k,
		input logic [3:0] map);
		apf_cfg_pkg::joy_t j;
		j.select = k.face_select;
		j.start  = k.face_start;
		j.up     = k.dpad_up;
		j.down   = k.dpad_down;
		j.left   = k.dpad_left;
		j.right  = k.dpad_right;
		case (map)
			// arcade layout
			4'h1: {j.btn_d, j.btn_c, j.btn_b, j.btn_a} = {k.face_a, k.face_x, k.face_b, k.face_y};
			// CD layout
			4'h2: {j.btn_d, j.btn_c, j.btn_b, j.btn_a} = {k.face_x, k.face_y, k.face_a, k.face_b};
			default: {j.btn_d, j.btn_c, j.btn_b, j.btn_a} = {k.face_y, k.face_x, k.face_b, k.face_a};
		endcase
		return j;
	endfunction

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			joystick_0   <= '0;
			joystick_1   <= '0;
			start_system <= 1'b0;
		end else begin
			joystick_0   <= remap(cont1_key, controller_map_1);
			joystick_1   <= remap(cont2_key, controller_map_2);
			// holding L1 on pad 1 keeps the core in reset
			start_system <= dataslot_allcomplete & core_run & ~cont1_key.trig_l1;
		end
	end

endmodule

// ==== design/apf_core_cfg_top.sv ====
// ========================================
// single clock, clk_74a only
// two pads, no analog inputs
// ========================================
`timescale 1ns/1ns

module apf_core_cfg_top (
	input  logic                   clk_74a,
	input  logic                   reset_l_main,
	input  apf_cfg_pkg::apb_req_t  apb,
	output logic [31:0]            prdata,
	input  apf_cfg_pkg::pad_keys_t cont1_key,
	input  apf_cfg_pkg::pad_keys_t cont2_key,
	input  logic                   dataslot_allcomplete,
	input  logic                   core_run,
	output apf_cfg_pkg::core_cfg_t cfg,
	output apf_cfg_pkg::p2_mask_t  p2rom_mask,
	output apf_cfg_pkg::m_mask_t   mrom_mask,
	output apf_cfg_pkg::v1_mask_t  v1rom_mask,
	output apf_cfg_pkg::joy_t      joystick_0,
	output apf_cfg_pkg::joy_t      joystick_1,
	output logic                   start_system
);

	apf_cfg_pkg::rom_wr_t rom_wr;

	apb_cfg_regs u_regs (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.apb          (apb),
		.prdata       (prdata),
		.cfg          (cfg),
		.rom_wr       (rom_wr)
	);

	// one size tracker per ROM window
	rom_mask_tracker #(.mask_t(apf_cfg_pkg::p2_mask_t)) u_p2_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.wr           (rom_wr.p2_wr),
		.addr         (rom_wr.addr),
		.mask         (p2rom_mask)
	);

	rom_mask_tracker #(.mask_t(apf_cfg_pkg::m_mask_t)) u_m_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.wr           (rom_wr.m_wr),
		.addr         (rom_wr.addr),
		.mask         (mrom_mask)
	);

	rom_mask_tracker #(.mask_t(apf_cfg_pkg::v1_mask_t)) u_v1_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.wr           (rom_wr.v1_wr),
		.addr         (rom_wr.addr),
		.mask         (v1rom_mask)
	);

	pad_input_stage u_pads (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.cont1_key            (cont1_key),
		.cont2_key            (cont2_key),
		.controller_map_1     (cfg.controller_map_1),
		.controller_map_2     (cfg.controller_map_2),
		.dataslot_allcomplete (dataslot_allcomplete),
		.core_run             (core_run),
		.joystick_0           (joystick_0),
		.joystick_1           (joystick_1),
		.start_system         (start_system)
	);

endmodule

// ==== sim/tb_clock.sv ====
// ========================================
// 40 ns clock, reset held low for 16 cycles
// ========================================
`timescale 1ns/1ns

module tb_clock (
	output logic clk_74a,
	output logic reset_l_main
);

	initial begin
		clk_74a = 1'b0;
		forever #20 clk_74a = ~clk_74a;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset_l_main = 1'b0;
		repeat (16) @(posedge clk_74a);
		@(negedge clk_74a);
		reset_l_main = 1'b1;
	end

endmodule

// ==== sim/tb_checker.sv ====
// ========================================
// cycle model of the config block, checked on
// every rising edge after reset
// ========================================
`timescale 1ns/1ns
`include "apf_cfg_defs.svh"

module tb_checker (
	input  logic                   clk_74a,
	input  logic                   reset_l_main,
	input  apf_cfg_pkg::apb_req_t  apb,
	input  logic [31:0]            prdata,
	input  apf_cfg_pkg::pad_keys_t cont1_key,
	input  apf_cfg_pkg::pad_keys_t cont2_key,
	input  logic                   dataslot_allcomplete,
	input  logic                   core_run,
	input  apf_cfg_pkg::core_cfg_t cfg,
	input  apf_cfg_pkg::p2_mask_t  p2rom_mask,
	input  apf_cfg_pkg::m_mask_t   mrom_mask,
	input  apf_cfg_pkg::v1_mask_t  v1rom_mask,
	input  apf_cfg_pkg::joy_t      joystick_0,
	input  apf_cfg_pkg::joy_t      joystick_1,
	input  logic                   start_system,
	input  int                     test_id,
	output int                     errors,
	output int                     checks
);

	localparam logic [31:0] cfg_base = `APF_CFG_BASE;

	// one entry per word offset, already cut to field width
	logic [31:0] regs [17];
	logic [23:0] p2_q;
	logic [23:0] m_q;
	logic [23:0] v1_q;
	logic [9:0]  joy0_q;
	logic [9:0]  joy1_q;
	logic [2:0]  pchip_q;
	logic        start_q;

	function automatic string test_label(input int id);
		case (id)
			1: return "reset_values";
			2: return "config_rw";
			3: return "rom_masks";
			4: return "pad_remap";
			5: return "cart_pchip";
			6: return "start_gate";
			default: return "idle";
		endcase
	endfunction

	function automatic logic [31:0] field_mask(input int idx);
		case (idx)
			2: return 32'hFF;
			3, 4, 5, 12, 16: return 32'h3;
			6, 9, 10: return 32'h1;
			7: return 32'h3F;
			11: return 32'h7;
			13, 14: return 32'hFFFF_FFFF;
			15: return 32'h00FF_FFFF;
			default: return 32'hF;
		endcase
	endfunction

	function automatic logic [31:0] reset_value(input int idx);
		case (idx)
			2: return 32'(`APF_RST_DIPSW);
			3: return 32'(`APF_RST_SYSTEM_TYPE);
			7: return 32'(`APF_RST_CH_ENABLE);
			8: return 32'(`APF_RST_SND_ENABLE);
			default: return 32'h0;
		endcase
	endfunction

	// -1 for anything outside the mapped word offsets
	function automatic int reg_index(input logic [31:0] addr);
		if (addr[31:8] != cfg_base[31:8] || addr[1:0] != 2'b00 || addr[7:2] > 6'd16)
			return -1;
		return int'(addr[7:2]);
	endfunction

	function automatic logic in_window(input logic [31:0] addr, input logic [31:0] prefix,
		input int w);
		return (addr >> (32 - w)) == prefix;
	endfunction

	// all ones up to the highest set address bit
	function automatic logic [23:0] size_mask(input logic [23:0] addr, input int w);
		logic [23:0] m;
		m = '0;
		for (int i = 0; i < w; i++)
			if (addr[i])
				m = 24'((25'd1 << (i + 1)) - 25'd1);
		return m;
	endfunction

	function automatic logic [2:0] pchip_decode(input logic main, input logic [2:0] sub);
		if (main)
			return 3'd2;
		case (sub)
			3'd1, 3'd2, 3'd3, 3'd4, 3'd5: return sub + 3'd2;
			default: return 3'd0;
		endcase
	endfunction

	function automatic logic [9:0] remap(input logic [15:0] k, input logic [3:0] map);
		logic [9:0] j;
		j[9] = k[14];
		j[8] = k[15];
		j[3] = k[0];
		j[2] = k[1];
		j[1] = k[2];
		j[0] = k[3];
		case (map)
			4'd1: j[7:4] = {k[4], k[6], k[5], k[7]};
			4'd2: j[7:4] = {k[6], k[7], k[4], k[5]};
			default: j[7:4] = {k[7], k[6], k[5], k[4]};
		endcase
		return j;
	endfunction

	function automatic apf_cfg_pkg::core_cfg_t expected_cfg();
		apf_cfg_pkg::core_cfg_t c;
		c.controller_map_1   = regs[0][3:0];
		c.controller_map_2   = regs[1][3:0];
		c.dipsw              = regs[2][7:0];
		c.system_type        = regs[3][1:0];
		c.memory_card_enable = regs[4][1:0];
		c.use_mouse          = regs[5][1:0];
		c.video_mode         = regs[6][0];
		c.ch_enable          = regs[7][5:0];
		c.snd_enable         = regs[8][3:0];
		c.use_pcm            = regs[10][0];
		c.cmc_chip           = regs[12][1:0];
		c.cart_chip          = regs[16][1:0];
		c.cart_pchip         = pchip_q;
		c.screen_x_pos       = regs[13];
		c.screen_y_pos       = regs[14];
		c.v2_offset          = regs[15][23:0];
		return c;
	endfunction

	task automatic compare_value(input string what, input logic [159:0] exp,
		input logic [159:0] act);
		checks = checks + 1;
		if (act !== exp) begin
			errors = errors + 1;
			$display("MISMATCH %s %s expected %0h actual %0h",
				test_label(test_id), what, exp, act);
		end
	endtask

	always @(posedge clk_74a) begin : model_step
		int          idx;
		logic [31:0] rd_exp;
		if (!reset_l_main) begin
			for (int i = 0; i < 17; i++)
				regs[i] = reset_value(i);
			p2_q    = '0;
			m_q     = '0;
			v1_q    = '0;
			joy0_q  = '0;
			joy1_q  = '0;
			pchip_q = '0;
			start_q = 1'b0;
			errors  = 0;
			checks  = 0;
		end else begin
			compare_value("cfg", 160'(expected_cfg()), 160'(cfg));
			compare_value("p2rom_mask", 160'(p2_q), 160'(p2rom_mask));
			compare_value("mrom_mask", 160'(m_q), 160'(mrom_mask));
			compare_value("v1rom_mask", 160'(v1_q), 160'(v1rom_mask));
			compare_value("joystick_0", 160'(joy0_q), 160'(joystick_0));
			compare_value("joystick_1", 160'(joy1_q), 160'(joystick_1));
			compare_value("start_system", 160'(start_q), 160'(start_system));
			idx = reg_index(apb.paddr);
			rd_exp = 32'h0;
			if (idx >= 0)
				rd_exp = regs[idx];
			if (apb.psel && apb.penable && !apb.pwrite)
				compare_value("prdata", 160'(rd_exp), 160'(prdata));

			// next state, all from values before this edge
			pchip_q = pchip_decode(regs[9][0], regs[11][2:0]);
			joy0_q  = remap(cont1_key, regs[0][3:0]);
			joy1_q  = remap(cont2_key, regs[1][3:0]);
			start_q = dataslot_allcomplete & core_run & ~cont1_key[8];
			if (apb.psel && apb.penable && apb.pwrite) begin
				if (idx >= 0)
					regs[idx] = apb.pwdata & field_mask(idx);
				if (in_window(apb.paddr, 32'(`APF_P2_PREFIX), `APF_P2_PREFIX_W))
					p2_q = p2_q | size_mask(apb.paddr[23:0], $bits(apf_cfg_pkg::p2_mask_t));
				if (in_window(apb.paddr, 32'(`APF_M_PREFIX), `APF_M_PREFIX_W))
					m_q = m_q | size_mask(apb.paddr[23:0], $bits(apf_cfg_pkg::m_mask_t));
				if (in_window(apb.paddr, 32'(`APF_V1_PREFIX), `APF_V1_PREFIX_W))
					v1_q = v1_q | size_mask(apb.paddr[23:0], $bits(apf_cfg_pkg::v1_mask_t));
			end
		end
	end

endmodule

// ==== sim/tb_top.sv ====
// ========================================
// stimulus changes on falling edges only
// run length bounded by a watchdog
// ========================================
`timescale 1ns/1ns
`include "apf_cfg_defs.svh"

module tb_top;

	localparam int n_cfg      = 40;
	localparam int n_unmapped = 12;
	localparam int n_rom      = 36;
	localparam int n_pad      = 16;
	localparam int n_pchip    = 16;
	localparam int n_start    = 32;
	// an APB access spans three falling edges
	localparam int est_cycles = 40 + 17 * 3 + n_cfg * 6 + n_unmapped * 12 + n_rom * 6
		+ 4 * (6 + n_pad) + n_pchip * 9 + n_start;
	localparam int timeout_ns = est_cycles * 2 * 40;

	logic                   clk_74a;
	logic                   reset_l_main;
	apf_cfg_pkg::apb_req_t  apb;
	logic [31:0]            prdata;
	apf_cfg_pkg::pad_keys_t cont1_key;
	apf_cfg_pkg::pad_keys_t cont2_key;
	logic                   dataslot_allcomplete;
	logic                   core_run;
	apf_cfg_pkg::core_cfg_t cfg;
	apf_cfg_pkg::p2_mask_t  p2rom_mask;
	apf_cfg_pkg::m_mask_t   mrom_mask;
	apf_cfg_pkg::v1_mask_t  v1rom_mask;
	apf_cfg_pkg::joy_t      joystick_0;
	apf_cfg_pkg::joy_t      joystick_1;
	logic                   start_system;
	int                     test_id;
	int                     errors;
	int                     checks;
	logic [15:0]            lfsr;
	logic [31:0]            addr;
	logic [31:0]            map;

	tb_clock clk0 (.*);
	apf_core_cfg_top dut0 (.*);
	tb_checker chk0 (.*);

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// 0 is P2, 1 is M, anything else V1
	function automatic logic [31:0] window_addr(input int sel, input logic [31:0] low);
		int          w;
		logic [31:0] prefix;
		w = `APF_V1_PREFIX_W;
		prefix = 32'(`APF_V1_PREFIX);
		if (sel == 0) begin
			w = `APF_P2_PREFIX_W;
			prefix = 32'(`APF_P2_PREFIX);
		end else if (sel == 1) begin
			w = `APF_M_PREFIX_W;
			prefix = 32'(`APF_M_PREFIX);
		end
		return (prefix << (32 - w)) | (low & ((32'h1 << (32 - w)) - 32'h1));
	endfunction

	task automatic apb_access(input logic wr, input logic [31:0] a, input logic [31:0] d);
		@(negedge clk_74a);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = wr;
		apb.paddr   = a;
		apb.pwdata  = d;
		@(negedge clk_74a);
		apb.penable = 1'b1;
		@(negedge clk_74a);
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic drive_pads(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_74a);
			cont1_key = apf_cfg_pkg::pad_keys_t'(16'(rand_bits(16)));
			cont2_key = apf_cfg_pkg::pad_keys_t'(16'(rand_bits(16)));
		end
	endtask

	initial begin
		apb = '0;
		cont1_key = '0;
		cont2_key = '0;
		dataslot_allcomplete = 1'b0;
		core_run = 1'b0;
		test_id = 0;
		lfsr = 16'd4062;
		wait (reset_l_main === 1'b1);

		test_id = 1;
		for (int i = 0; i < 17; i++)
			apb_access(1'b0, `APF_CFG_BASE + 32'(i * 4), 32'h0);

		test_id = 2;
		for (int i = 0; i < n_cfg; i++) begin
			addr = `APF_CFG_BASE + (rand_bits(5) % 17) * 4;
			apb_access(1'b1, addr, rand_bits(32));
			apb_access(1'b0, addr, 32'h0);
		end
		for (int i = 0; i < n_unmapped; i++) begin
			addr = `APF_CFG_BASE + 32'h44 + rand_bits(7);
			apb_access(1'b1, addr, rand_bits(32));
			apb_access(1'b0, addr, 32'h0);
			// misaligned inside the map, then far outside every window
			apb_access(1'b0, `APF_CFG_BASE + (rand_bits(5) % 17) * 4 + 1 + rand_bits(1), 32'h0);
			apb_access(1'b0, 32'h3000_0000 | rand_bits(24), 32'h0);
		end

		test_id = 3;
		for (int i = 0; i < n_rom; i++) begin
			addr = window_addr(int'(rand_bits(2) % 3), rand_bits(24) >> (rand_bits(5) % 24));
			apb_access(1'b1, addr, rand_bits(32));
			apb_access(1'b0, addr, 32'h0);
		end

		test_id = 4;
		for (int m = 0; m < 4; m++) begin
			map = (m < 3) ? 32'(m) : 32'd3 + rand_bits(4) % 13;
			apb_access(1'b1, `APF_CFG_BASE + 32'(`APF_REG_CTRL_MAP1), map);
			apb_access(1'b1, `APF_CFG_BASE + 32'(`APF_REG_CTRL_MAP2), map);
			drive_pads(n_pad);
		end

		test_id = 5;
		for (int i = 0; i < n_pchip; i++) begin
			apb_access(1'b1, `APF_CFG_BASE + 32'(`APF_REG_PCHIP_MAIN), rand_bits(1));
			apb_access(1'b1, `APF_CFG_BASE + 32'(`APF_REG_PCHIP_SUB), rand_bits(3));
			repeat (3) @(negedge clk_74a);
		end

		test_id = 6;
		for (int i = 0; i < n_start; i++) begin
			@(negedge clk_74a);
			dataslot_allcomplete = rand_bits(1) != 32'h0;
			core_run = rand_bits(1) != 32'h0;
			cont1_key.trig_l1 = rand_bits(1) != 32'h0;
		end

		repeat (3) @(negedge clk_74a);
		test_id = 0;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("timeout: run did not finish within %0d ns", timeout_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== apf_core_cfg.f ====
+incdir+design
design/apf_cfg_pkg.sv
design/apb_cfg_regs.sv
design/rom_mask_tracker.sv
design/pad_input_stage.sv
design/apf_core_cfg_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the config block testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f apf_core_cfg.f -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"
